// File: source/msx_glue_pkg.sv
// Shared widths, I/O port bases and SDRAM region bases of the MSX glue logic
// SDRAM region bases hold only the fixed upper part of the 23-bit byte address

package msx_glue_pkg;

	// --------------------------------------------------
	// Data and address widths
	// --------------------------------------------------
	typedef logic [7:0]		byte_t;				// CPU / SDRAM data byte
	typedef logic [15:0]	cpu_addr_t;			// Z80 address bus
	typedef logic [22:0]	sdram_addr_t;		// SDRAM byte address
	typedef logic [21:0]	rom_bank_addr_t;	// MegaROM mapper output
	typedef logic [17:0]	kanji_addr_t;		// Kanji ROM pointer
	typedef logic [3:0]		div12_t;			// Divide-by-12 count

	// Last count of the CPU / PSG divider (42.95MHz / 12 = 3.58MHz)
	localparam div12_t CPU_DIV_LAST = 4'd11;

	// --------------------------------------------------
	// I/O port bases
	// --------------------------------------------------
	localparam byte_t PORT_PPI		= 8'hA8;	// A8h-ABh
	localparam byte_t PORT_PSG		= 8'hA0;	// A0h-A3h
	localparam byte_t PORT_VDP		= 8'h98;	// 98h-99h
	localparam byte_t PORT_KANJI	= 8'hD8;	// D8h-DBh

	// Floating bus value when nothing drives it
	localparam byte_t IDLE_BYTE		= 8'hFF;

	// --------------------------------------------------
	// SDRAM region bases, address bits above bit 12
	// --------------------------------------------------
	// JIS1/JIS2 font, 256KB
	localparam logic [4:0] BASE_KANJI			= 5'b000_01;
	// Mapper RAM in slot 3-0, 64KB
	localparam logic [6:0] BASE_MAPPER_RAM		= 7'b100_0000;
	// Slot 1 cartridge, 2MB
	localparam logic [1:0] BASE_MEGAROM1		= 2'b01;
	// Slot 2 cartridge, 1MB
	localparam logic [2:0] BASE_MEGAROM2		= 3'b001;
	// MSX logo and ExtBASIC, slot 0-3
	localparam logic [7:0] BASE_LOGO_EXTBASIC	= 8'b000_0011_1;
	localparam logic [8:0] BASE_MSX_MUSIC		= 9'b001_0011_01;	// Slot 0-2
	localparam logic [8:0] BASE_IOT_BASIC		= 9'b010_0011_00;	// Slot 0-1
	// SUB-ROM, slot 3-1 page 0 (top bit is zero)
	localparam logic [8:0] BASE_SUB_ROM			= 9'b0_000_1000_0;
	localparam logic [7:0] BASE_KANJI_BASIC		= 8'b000_0010_1;	// Slot 3-1, pages 1-3
	localparam logic [7:0] BASE_MAIN_ROM		= 8'b000_0010_0;	// Slot 0-0, 32KB
	localparam logic [6:0] BASE_NEXTOR			= 7'b000_0000;		// Slot 3-2, banks 0-7

endpackage

// File: source/clock_enables.sv
// Clock enables derived from clk42m, no second clock domain
// cpu_enable also drives the PSG; it is held off during freeze and SDRAM init

`timescale 1ns/1ps

module clock_enables
	import msx_glue_pkg::*;
(
	input	logic	clk42m,
	input	logic	ff_reset_n,
	input	logic	cpu_freeze,			// ESP32 loader owns the SDRAM
	input	logic	sdram_init_busy,	// SDRAM controller still in init
	output	logic	half_enable,		// UART strobe, every 2nd cycle
	output	logic	cpu_enable			// Z80 / PSG strobe, every 12th cycle
);
	logic	ff_half;
	div12_t	ff_div;

	// --------------------------------------------------
	// Divide by 2
	// --------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_half <= 1'b0;
		end
		else begin
			ff_half <= ~ff_half;
		end
	end

	assign half_enable = ff_half;

	// --------------------------------------------------
	// Divide by 12
	// --------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_div <= '0;
		end
		else if (cpu_freeze) begin
			ff_div <= '0;					// Restart phase when loader lets go
		end
		else if (ff_div == CPU_DIV_LAST) begin
			ff_div <= '0;
		end
		else begin
			ff_div <= ff_div + 4'd1;
		end
	end

	// Last count only, gated by both hold-off conditions
	assign cpu_enable = (ff_div == CPU_DIV_LAST) && !sdram_init_busy && !cpu_freeze;

endmodule

// File: source/io_port_decode.sv
// Z80 I/O chip selects, only the low address byte is decoded
// Selects are combinational and active low

`timescale 1ns/1ps

module io_port_decode
	import msx_glue_pkg::*;
(
	input	logic		iorq_n,
	input	cpu_addr_t	a,
	output	logic		ppi_cs_n,
	output	logic		psg_cs_n,
	output	logic		vdp_cs_n,
	output	logic		kanji_cs_n
);
	byte_t	w_port;
	byte_t	w_port_quad;		// Port number with 2 LSBs cleared
	byte_t	w_port_pair;		// Port number with LSB cleared
	logic	w_ppi_hit;
	logic	w_psg_hit;
	logic	w_vdp_hit;
	logic	w_kanji_hit;

	assign w_port		= a[7:0];
	assign w_port_quad	= {w_port[7:2], 2'b00};
	assign w_port_pair	= {w_port[7:1], 1'b0};

	// --------------------------------------------------
	// Group match
	// --------------------------------------------------
	assign w_ppi_hit	= (w_port_quad == PORT_PPI);	// Four ports
	assign w_psg_hit	= (w_port_quad == PORT_PSG);	// Four ports
	assign w_vdp_hit	= (w_port_pair == PORT_VDP);	// Data / control pair
	assign w_kanji_hit	= (w_port_quad == PORT_KANJI);	// JIS1 and JIS2 pointers

	// Qualify with the I/O cycle
	assign ppi_cs_n		= !(!iorq_n && w_ppi_hit);
	assign psg_cs_n		= !(!iorq_n && w_psg_hit);
	assign vdp_cs_n		= !(!iorq_n && w_vdp_hit);
	assign kanji_cs_n	= !(!iorq_n && w_kanji_hit);

endmodule

// File: source/read_data_return.sv
// Registered byte returned to the Z80, one cycle after the valid strobe
// Driving cpu_rdata onto the bidirectional data bus is left to the user

`timescale 1ns/1ps

module read_data_return
	import msx_glue_pkg::*;
(
	input	logic	clk42m,
	input	logic	ff_reset_n,
	input	logic	rd_n,
	input	byte_t	sdram_q,
	input	logic	sdram_q_en,
	input	byte_t	vdp_q,
	input	logic	vdp_q_en,
	input	byte_t	uart_q,
	input	logic	uart_q_en,
	input	byte_t	expslt0_q,		// Slot 0 expander register
	input	logic	expslt0_q_en,
	input	byte_t	expslt3_q,		// Slot 3 expander register
	input	logic	expslt3_q_en,
	input	byte_t	ppi_q,
	input	logic	ppi_q_en,
	input	byte_t	psg_q,
	input	logic	psg_q_en,
	output	byte_t	cpu_rdata
);
	byte_t	ff_rdata;

	// --------------------------------------------------
	// Priority capture
	// --------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= IDLE_BYTE;
		end
		else if (sdram_q_en) begin
			ff_rdata <= sdram_q;			// Memory first
		end
		else if (vdp_q_en) begin
			ff_rdata <= vdp_q;
		end
		else if (uart_q_en) begin
			ff_rdata <= uart_q;
		end
		else if (expslt0_q_en) begin
			ff_rdata <= expslt0_q;
		end
		else if (expslt3_q_en) begin
			ff_rdata <= expslt3_q;
		end
		else if (ppi_q_en) begin
			ff_rdata <= ppi_q;
		end
		else if (psg_q_en) begin
			ff_rdata <= psg_q;
		end
		else if (rd_n) begin
			ff_rdata <= IDLE_BYTE;			// Bus released, pull up
		end
		// Read in progress, keep last byte for the CPU
	end

	assign cpu_rdata = ff_rdata;

endmodule

// File: source/sdram_memory_map.sv
// Combinational SDRAM request mux: SPI loader, then Kanji ROM, then Z80
// Slot selects are assumed one-hot; the first active one in map order wins

`timescale 1ns/1ps

module sdram_memory_map
	import msx_glue_pkg::*;
(
	input	logic			cpu_freeze,
	input	logic			kanji_en,
	input	logic			spi_mreq_n,
	input	sdram_addr_t	spi_address,
	input	byte_t			spi_d,
	input	logic			mreq_n,
	input	logic			iorq_n,
	input	logic			rd_n,
	input	logic			wr_n,
	input	cpu_addr_t		a,
	input	byte_t			d,
	input	kanji_addr_t	kanji_address,
	input	logic			sltsl1,
	input	logic			sltsl2,
	input	logic			sltsl00,
	input	logic			sltsl01,
	input	logic			sltsl02,
	input	logic			sltsl03,
	input	logic			sltsl30,
	input	logic			sltsl31,
	input	logic			sltsl32,
	input	rom_bank_addr_t	megarom1_address,
	input	rom_bank_addr_t	megarom2_address,
	input	logic			megarom1_mem_cs_n,
	input	logic			megarom2_mem_cs_n,
	input	logic			megarom1_rd_n,
	input	logic			megarom2_rd_n,
	output	sdram_addr_t	sdram_address,
	output	byte_t			sdram_d,
	output	logic			sdram_mreq_n,
	output	logic			sdram_rd_n,
	output	logic			sdram_wr_n
);
	logic	[9:0]	w_upper;		// Address bits 22:13
	logic	[12:0]	w_lower;		// Address bits 12:0
	logic	[1:0]	w_page;			// Z80 16KB page

	assign w_page = a[15:14];

	// --------------------------------------------------
	// Upper address, region select
	// --------------------------------------------------
	always_comb begin
		if (cpu_freeze) begin
			w_upper = spi_address[22:13];						// Loader, flat
		end
		else if (kanji_en) begin
			w_upper = {BASE_KANJI, kanji_address[17:13]};
		end
		else if (sltsl30) begin
			w_upper = {BASE_MAPPER_RAM, a[15:13]};
		end
		else if (sltsl1) begin
			w_upper = {BASE_MEGAROM1, megarom1_address[20:13]};
		end
		else if (sltsl2) begin
			w_upper = {BASE_MEGAROM2, megarom2_address[19:13]};
		end
		else if (sltsl03) begin
			w_upper = {BASE_LOGO_EXTBASIC, a[14:13]};
		end
		else if (sltsl02) begin
			w_upper = {BASE_MSX_MUSIC, a[13]};					// 16KB image
		end
		else if (sltsl01) begin
			w_upper = {BASE_IOT_BASIC, a[13]};
		end
		else if (sltsl31 && (w_page == 2'b00)) begin
			w_upper = {BASE_SUB_ROM, a[13]};
		end
		else if (sltsl31) begin
			w_upper = {BASE_KANJI_BASIC, a[15], a[13]};		// Pages 1-3 folded
		end
		else if (sltsl00) begin
			w_upper = {BASE_MAIN_ROM, a[14:13]};
		end
		else if (sltsl32) begin
			w_upper = {BASE_NEXTOR, a[15:13]};
		end
		else begin
			w_upper = '0;										// Slot 3-3 unmapped
		end
	end

	// --------------------------------------------------
	// Low address, write data, request
	// --------------------------------------------------
	assign w_lower = cpu_freeze ? spi_address[12:0] :
					 kanji_en   ? kanji_address[12:0] :
								  a[12:0];

	assign sdram_address	= {w_upper, w_lower};
	assign sdram_d			= cpu_freeze ? spi_d : d;

	// Kanji fetch requests on its own, Z80 uses mreq_n
	assign sdram_mreq_n		= cpu_freeze ? spi_mreq_n :
							  kanji_en   ? 1'b0 :
										   mreq_n;

	// Only the loader and mapper RAM may write
	assign sdram_wr_n		= cpu_freeze ? spi_mreq_n :
							  sltsl30    ? wr_n :
										   1'b1;

	// --------------------------------------------------
	// Read strobe, readable windows only
	// --------------------------------------------------
	always_comb begin
		sdram_rd_n = 1'b1;
		if (kanji_en) begin
			sdram_rd_n = 1'b0;
		end
		else if (!iorq_n) begin
			sdram_rd_n = 1'b1;				// Never on I/O cycles
		end
		else if (sltsl30) begin
			sdram_rd_n = rd_n;
		end
		else if (!megarom1_mem_cs_n) begin
			sdram_rd_n = megarom1_rd_n;		// Mapper decides
		end
		else if (!megarom2_mem_cs_n) begin
			sdram_rd_n = megarom2_rd_n;
		end
		else if (sltsl03 && (w_page == 2'b01 || w_page == 2'b10)) begin
			sdram_rd_n = rd_n;
		end
		else if ((sltsl02 || sltsl01) && (w_page == 2'b01)) begin
			sdram_rd_n = rd_n;				// Page 1 ROMs
		end
		else if (sltsl31) begin
			sdram_rd_n = rd_n;
		end
		else if (sltsl00 && !a[15]) begin
			sdram_rd_n = rd_n;
		end
		else if (sltsl32 && (w_page == 2'b01 || w_page == 2'b10)) begin
			sdram_rd_n = rd_n;
		end
	end

endmodule

// File: source/msx_glue_top.sv
// MSX glue logic around external Z80, VDP, PSG, PPI, UART and SDRAM blocks
// Single clock clk42m; the CPU data bus driver is outside this top level

`timescale 1ns/1ps

module msx_glue_top
	import msx_glue_pkg::*;
(
	input	logic			clk42m,
	input	logic			ff_reset_n,
	input	logic			cpu_freeze,
	input	logic			sdram_init_busy,
	// Z80 bus
	input	logic			mreq_n,
	input	logic			iorq_n,
	input	logic			rd_n,
	input	logic			wr_n,
	input	cpu_addr_t		a,
	input	byte_t			d,
	// Read sources
	input	byte_t			sdram_q,
	input	logic			sdram_q_en,
	input	byte_t			vdp_q,
	input	logic			vdp_q_en,
	input	byte_t			uart_q,
	input	logic			uart_q_en,
	input	byte_t			expslt0_q,
	input	logic			expslt0_q_en,
	input	byte_t			expslt3_q,
	input	logic			expslt3_q_en,
	input	byte_t			ppi_q,
	input	logic			ppi_q_en,
	input	byte_t			psg_q,
	input	logic			psg_q_en,
	// SDRAM requesters
	input	logic			spi_mreq_n,
	input	sdram_addr_t	spi_address,
	input	byte_t			spi_d,
	input	logic			kanji_en,
	input	kanji_addr_t	kanji_address,
	input	logic			sltsl1,
	input	logic			sltsl2,
	input	logic			sltsl00,
	input	logic			sltsl01,
	input	logic			sltsl02,
	input	logic			sltsl03,
	input	logic			sltsl30,
	input	logic			sltsl31,
	input	logic			sltsl32,
	input	rom_bank_addr_t	megarom1_address,
	input	rom_bank_addr_t	megarom2_address,
	input	logic			megarom1_mem_cs_n,
	input	logic			megarom2_mem_cs_n,
	input	logic			megarom1_rd_n,
	input	logic			megarom2_rd_n,
	// Outputs
	output	logic			half_enable,
	output	logic			cpu_enable,
	output	logic			ppi_cs_n,
	output	logic			psg_cs_n,
	output	logic			vdp_cs_n,
	output	logic			kanji_cs_n,
	output	byte_t			cpu_rdata,
	output	sdram_addr_t	sdram_address,
	output	byte_t			sdram_d,
	output	logic			sdram_mreq_n,
	output	logic			sdram_rd_n,
	output	logic			sdram_wr_n
);

	// --------------------------------------------------
	// Strobes and port decode
	// --------------------------------------------------
	clock_enables u_clock_enables (.*);

	io_port_decode u_io_port_decode (.*);

	// --------------------------------------------------
	// CPU read path and SDRAM map
	// --------------------------------------------------
	read_data_return u_read_data_return (.*);

	sdram_memory_map u_sdram_memory_map (.*);

endmodule

// File: testbench/msx_glue_chk.sv
// Bound into msx_glue_top; slot selects are expected one-hot or all low
// MegaROM chip selects are expected to follow their slot selects

`timescale 1ns/1ps

module msx_glue_chk
	import msx_glue_pkg::*;
(
	input	logic			clk42m, ff_reset_n, cpu_freeze, sdram_init_busy,
	input	logic			mreq_n, iorq_n, rd_n, wr_n, kanji_en, spi_mreq_n,
	input	cpu_addr_t		a,
	input	byte_t			d, spi_d, cpu_rdata, sdram_d,
	input	byte_t			sdram_q, vdp_q, uart_q, expslt0_q, expslt3_q, ppi_q, psg_q,
	input	logic			sdram_q_en, vdp_q_en, uart_q_en, expslt0_q_en,
	input	logic			expslt3_q_en, ppi_q_en, psg_q_en,
	input	sdram_addr_t	spi_address, sdram_address,
	input	kanji_addr_t	kanji_address,
	input	logic			sltsl1, sltsl2, sltsl00, sltsl01, sltsl02, sltsl03,
	input	logic			sltsl30, sltsl31, sltsl32,
	input	rom_bank_addr_t	megarom1_address, megarom2_address,
	input	logic			megarom1_rd_n, megarom2_rd_n,
	input	logic			half_enable, cpu_enable, ppi_cs_n, psg_cs_n, vdp_cs_n, kanji_cs_n,
	input	logic			sdram_mreq_n, sdram_rd_n, sdram_wr_n
);
	int unsigned	err_count = 0;		// Failed assertions so far
	logic			half_q;
	div12_t			phase_q;			// Cycles since reset, freeze or strobe
	logic			cpu_exp;
	byte_t			rdata_next;
	byte_t			rdata_q;
	logic	[3:0]	cs_exp;
	logic	[9:0]	upper_exp;
	sdram_addr_t	addr_exp;
	logic	[9:0]	req_exp;			// {d, mreq_n, wr_n}
	logic			rd_exp;
	logic	[1:0]	page;

	function automatic logic cs_expected(logic iorq, byte_t port, byte_t base, byte_t mask);
		return !(!iorq && ((port & mask) == base));
	endfunction

	// --------------------------------------------------
	// Reference models
	// --------------------------------------------------
	always_ff @(posedge clk42m) begin
		half_q <= ff_reset_n ? ~half_q : 1'b0;
		phase_q <= (!ff_reset_n || cpu_freeze || phase_q == 4'd11) ? 4'd0 : phase_q + 4'd1;
		rdata_q <= ff_reset_n ? rdata_next : IDLE_BYTE;
	end

	assign cpu_exp = (phase_q == 4'd11) && !cpu_freeze && !sdram_init_busy;

	always_comb begin
		rdata_next = rdata_q;						// Hold while reading
		if (sdram_q_en)			rdata_next = sdram_q;
		else if (vdp_q_en)		rdata_next = vdp_q;
		else if (uart_q_en)		rdata_next = uart_q;
		else if (expslt0_q_en)	rdata_next = expslt0_q;
		else if (expslt3_q_en)	rdata_next = expslt3_q;
		else if (ppi_q_en)		rdata_next = ppi_q;
		else if (psg_q_en)		rdata_next = psg_q;
		else if (rd_n)			rdata_next = IDLE_BYTE;
	end

	assign cs_exp = {cs_expected(iorq_n, a[7:0], PORT_PPI, 8'hFC),
					 cs_expected(iorq_n, a[7:0], PORT_PSG, 8'hFC),
					 cs_expected(iorq_n, a[7:0], PORT_VDP, 8'hFE),
					 cs_expected(iorq_n, a[7:0], PORT_KANJI, 8'hFC)};

	assign page = a[15:14];

	always_comb begin
		upper_exp = '0;								// No slot, unmapped
		if (sltsl30)		upper_exp = {BASE_MAPPER_RAM, a[15:13]};
		else if (sltsl1)	upper_exp = {BASE_MEGAROM1, megarom1_address[20:13]};
		else if (sltsl2)	upper_exp = {BASE_MEGAROM2, megarom2_address[19:13]};
		else if (sltsl03)	upper_exp = {BASE_LOGO_EXTBASIC, a[14:13]};
		else if (sltsl02)	upper_exp = {BASE_MSX_MUSIC, a[13]};
		else if (sltsl01)	upper_exp = {BASE_IOT_BASIC, a[13]};
		else if (sltsl31)	upper_exp = (page == 2'd0) ? {BASE_SUB_ROM, a[13]} :
										 {BASE_KANJI_BASIC, a[15], a[13]};
		else if (sltsl00)	upper_exp = {BASE_MAIN_ROM, a[14:13]};
		else if (sltsl32)	upper_exp = {BASE_NEXTOR, a[15:13]};
	end

	always_comb begin
		rd_exp = 1'b1;
		if (kanji_en)		rd_exp = 1'b0;
		else if (!iorq_n)	rd_exp = 1'b1;				// I/O never reads SDRAM
		else if (sltsl30)	rd_exp = rd_n;
		else if (sltsl1)	rd_exp = megarom1_rd_n;
		else if (sltsl2)	rd_exp = megarom2_rd_n;
		else if (sltsl03)	rd_exp = (page == 2'd1 || page == 2'd2) ? rd_n : 1'b1;
		else if (sltsl02 || sltsl01)	rd_exp = (page == 2'd1) ? rd_n : 1'b1;
		else if (sltsl31)	rd_exp = rd_n;
		else if (sltsl00)	rd_exp = a[15] ? 1'b1 : rd_n;
		else if (sltsl32)	rd_exp = (page == 2'd1 || page == 2'd2) ? rd_n : 1'b1;
	end

	assign addr_exp = cpu_freeze ? spi_address :
					  kanji_en   ? {BASE_KANJI, kanji_address} : {upper_exp, a[12:0]};
	assign req_exp  = cpu_freeze ? {spi_d, spi_mreq_n, spi_mreq_n} :
					  {d, !kanji_en && mreq_n, !sltsl30 || wr_n};

	// --------------------------------------------------
	// Assertions
	// --------------------------------------------------
	a_half: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		half_enable == half_q) else begin
		err_count++;
		$error("ERR %0t half_enable got %b expected %b", $time, half_enable, half_q);
	end

	a_cpu: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		cpu_enable == cpu_exp) else begin
		err_count++;
		$error("ERR %0t cpu_enable got %b expected %b at phase %0d", $time,
			cpu_enable, cpu_exp, phase_q);
	end

	a_cs: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		{ppi_cs_n, psg_cs_n, vdp_cs_n, kanji_cs_n} == cs_exp) else begin
		err_count++;
		$error("ERR %0t cs_n got %b expected %b", $time,
			{ppi_cs_n, psg_cs_n, vdp_cs_n, kanji_cs_n}, cs_exp);
	end

	a_rdata: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		cpu_rdata == rdata_q) else begin
		err_count++;
		$error("ERR %0t cpu_rdata got %h expected %h", $time, cpu_rdata, rdata_q);
	end

	a_addr: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		sdram_address == addr_exp) else begin
		err_count++;
		$error("ERR %0t sdram_address got %h expected %h", $time, sdram_address, addr_exp);
	end

	a_req: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		{sdram_d, sdram_mreq_n, sdram_wr_n} == req_exp) else begin
		err_count++;
		$error("ERR %0t sdram_d/mreq_n/wr_n got %h expected %h", $time,
			{sdram_d, sdram_mreq_n, sdram_wr_n}, req_exp);
	end

	// Read strobe is not defined for the loader
	a_rd: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!cpu_freeze |-> sdram_rd_n == rd_exp) else begin
		err_count++;
		$error("ERR %0t sdram_rd_n got %b expected %b", $time, sdram_rd_n, rd_exp);
	end

endmodule

bind msx_glue_top msx_glue_chk chk_i (.*);

// File: testbench/tb_msx_glue.sv
// Random traffic on the glue inputs, driven on the falling edge
// All checking is done by the bound assertions

`timescale 1ns/1ps

module tb_msx_glue
	import msx_glue_pkg::*;
;
	localparam int TOTAL_CYCLES	= 2 + 60 + 30 + 40 + 30 + 40 + 40 + 400;
	localparam int MARGIN		= 100;

	logic			clk42m = 1'b0;
	logic			ff_reset_n = 1'b0;
	logic			cpu_freeze = 1'b0, sdram_init_busy = 1'b0;
	logic			mreq_n = 1'b1, iorq_n = 1'b1, rd_n = 1'b1, wr_n = 1'b1;
	cpu_addr_t		a = '0;
	byte_t			d = '0, spi_d = '0;
	byte_t			sdram_q = '0, vdp_q = '0, uart_q = '0, expslt0_q = '0;
	byte_t			expslt3_q = '0, ppi_q = '0, psg_q = '0;
	logic			sdram_q_en = 1'b0, vdp_q_en = 1'b0, uart_q_en = 1'b0;
	logic			expslt0_q_en = 1'b0, expslt3_q_en = 1'b0, ppi_q_en = 1'b0, psg_q_en = 1'b0;
	logic			spi_mreq_n = 1'b1, kanji_en = 1'b0;
	sdram_addr_t	spi_address = '0;
	kanji_addr_t	kanji_address = '0;
	logic			sltsl1 = 1'b0, sltsl2 = 1'b0, sltsl00 = 1'b0, sltsl01 = 1'b0;
	logic			sltsl02 = 1'b0, sltsl03 = 1'b0, sltsl30 = 1'b0, sltsl31 = 1'b0;
	logic			sltsl32 = 1'b0;
	rom_bank_addr_t	megarom1_address = '0, megarom2_address = '0;
	logic			megarom1_mem_cs_n = 1'b1, megarom2_mem_cs_n = 1'b1;
	logic			megarom1_rd_n = 1'b1, megarom2_rd_n = 1'b1;
	logic			half_enable, cpu_enable, ppi_cs_n, psg_cs_n, vdp_cs_n, kanji_cs_n;
	byte_t			cpu_rdata, sdram_d;
	sdram_addr_t	sdram_address;
	logic			sdram_mreq_n, sdram_rd_n, sdram_wr_n;
	logic	[31:0]	lcg_state = 32'ha8eb_dfa7;

	msx_glue_top dut_i (.*);

	initial begin
		forever #50 clk42m = ~clk42m;			// 100ns period
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic select_slot(input int idx);		// 9 leaves all low
		sltsl30 = (idx == 0);
		sltsl1 = (idx == 1);
		sltsl2 = (idx == 2);
		sltsl03 = (idx == 3);
		sltsl02 = (idx == 4);
		sltsl01 = (idx == 5);
		sltsl31 = (idx == 6);
		sltsl00 = (idx == 7);
		sltsl32 = (idx == 8);
		megarom1_mem_cs_n = !sltsl1;				// Mappers answer in their slot
		megarom2_mem_cs_n = !sltsl2;
	endtask

	task automatic randomize_bus();
		logic [31:0] r;
		r = next_rand();
		{iorq_n, mreq_n, rd_n, wr_n, megarom1_rd_n, megarom2_rd_n, spi_mreq_n} = r[31:25];
		a = r[15:0];
		d = r[23:16];
		r = next_rand();
		{sdram_q, vdp_q, uart_q, expslt0_q} = r;
		r = next_rand();
		{expslt3_q, ppi_q, psg_q, spi_d} = r;
		r = next_rand();
		// Sparse valids so every priority level gets a turn
		sdram_q_en = (r[2:0] == 3'd0);
		vdp_q_en = (r[5:3] == 3'd0);
		uart_q_en = (r[8:6] == 3'd0);
		expslt0_q_en = (r[11:9] == 3'd0);
		expslt3_q_en = (r[14:12] == 3'd0);
		ppi_q_en = (r[17:15] == 3'd0);
		psg_q_en = (r[20:18] == 3'd0);
		select_slot(int'(r[31:21] % 10));
		r = next_rand();
		spi_address = r[22:0];
		kanji_address = r[31:14];
		r = next_rand();
		megarom1_address = r[21:0];
		megarom2_address = {r[31:22], r[11:0]};
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			@(negedge clk42m);
			randomize_bus();
		end
	endtask

	// --------------------------------------------------
	// Failure monitor and watchdog
	// --------------------------------------------------
	always @(negedge clk42m) begin
		if (dut_i.chk_i.err_count != 0) begin
			$display("sim failed");
			$fatal(1, "Assertion failure reported by the checker");
		end
	end

	initial begin
		#((TOTAL_CYCLES + MARGIN) * 100);
		$display("sim failed");
		$fatal(1, "Watchdog expired before the test sequence finished");
	end

	initial begin
		repeat (2) @(negedge clk42m);
		ff_reset_n = 1'b1;
		run_cycles(60);								// Free running strobes
		sdram_init_busy = 1'b1;
		run_cycles(30);
		sdram_init_busy = 1'b0;
		run_cycles(40);
		cpu_freeze = 1'b1;							// Loader owns SDRAM
		run_cycles(30);
		cpu_freeze = 1'b0;
		run_cycles(40);
		kanji_en = 1'b1;
		run_cycles(40);
		kanji_en = 1'b0;
		run_cycles(400);							// Decode, read return, slots
		@(negedge clk42m);
		if (dut_i.chk_i.err_count != 0) begin
			$display("sim failed");
			$fatal(1, "Assertion failure reported by the checker");
		end
		else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// File: msx_glue.f
source/msx_glue_pkg.sv
source/clock_enables.sv
source/io_port_decode.sv
source/read_data_return.sv
source/sdram_memory_map.sv
source/msx_glue_top.sv
testbench/msx_glue_chk.sv
testbench/tb_msx_glue.sv

// File: Makefile
# Verilator build for the MSX glue logic

TOOL      = verilator
FLAGS     = --binary --timing --assert
LINT_OPTS = --lint-only --timing --assert
TOP       = tb_msx_glue
RTL_TOP   = msx_glue_top
FILELIST  = msx_glue.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | \
		awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
